// ==== common/bus_params.svh ====
`ifndef BUS_PARAMS_SVH
`define BUS_PARAMS_SVH

// Fast cycles per slow tick, 2 or more.
`define BUS_CLOCK_RATIO 4

// RAM depth in 32-bit words.
`define BUS_RAM_WORDS 256

// Address map.
`define BUS_RAM_BASE 32'h0000_0000
`define BUS_TIMER_BASE 32'h1000_0000 // Count, compare and flag words.

`endif

// ==== common/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

  // Byte address.
  typedef logic [31:0] addr_t;

  typedef logic [31:0] data_t;

  // One write enable per byte, all zero for a read.
  typedef logic [3:0] strobe_t;

  // Request, held steady by the requester until ready.
  typedef struct packed {
    logic    valid;
    addr_t   addr;
    data_t   wdata;
    strobe_t wstrb;
  } mem_req_t;

  // Response. ready marks the cycle that carries rdata.
  typedef struct packed {
    logic  ready;
    data_t rdata;
  } mem_rsp_t;

  // Bridge FSM.
  typedef enum logic [1:0] {
    idle,     // Waiting for a fast request.
    launch,   // Request held, waiting for a tick.
    wait_rsp, // Slow valid raised.
    reply     // Fast ready pulse.
  } bridge_state_t;

endpackage

`default_nettype wire

// ==== bridge/rate_bridge.sv ====
`default_nettype none

`include "bus_params.svh"

module rate_bridge (
  input  logic              clock,
  input  logic              reset,
  input  bus_pkg::mem_req_t fast_req,
  output bus_pkg::mem_rsp_t fast_rsp,
  output logic              slow_tick,
  output bus_pkg::mem_req_t slow_req,
  input  bus_pkg::mem_rsp_t slow_rsp
);
  import bus_pkg::*;

  localparam int ratio = `BUS_CLOCK_RATIO;
  localparam int count_width = $clog2(ratio);
  localparam logic [count_width-1:0] count_last = count_width'(ratio - 1);

  logic [count_width-1:0] tick_count;
  bridge_state_t          state;
  logic                   slow_valid;
  mem_req_t               held_req;
  data_t                  held_rdata;
  logic                   take_req;
  logic                   take_rsp;

  // Slow tick generator.
  always_ff @(posedge clock) begin
    if (!reset) begin
      tick_count <= '0;
    end else if (slow_tick) begin
      tick_count <= '0;
    end else begin
      tick_count <= tick_count + 1'b1;
    end
  end

  assign slow_tick = (tick_count == count_last);

  assign take_req = (state == idle) && fast_req.valid;
  assign take_rsp = (state == wait_rsp) && slow_tick && slow_rsp.ready;

  always_ff @(posedge clock) begin
    if (!reset) begin
      state      <= idle;
      slow_valid <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (fast_req.valid) begin
            state <= launch;
          end
        end
        launch: begin
          if (slow_tick) begin
            slow_valid <= 1'b1; // Held for whole slow periods.
            state      <= wait_rsp;
          end
        end
        wait_rsp: begin
          if (take_rsp) begin
            slow_valid <= 1'b0;
            state      <= reply;
          end
        end
        reply: begin
          // The requester may still show the old request this cycle.
          state <= idle;
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // Request copy and captured read data.
  always_ff @(posedge clock) begin
    if (take_req) begin
      held_req <= fast_req;
    end
    if (take_rsp) begin
      held_rdata <= slow_rsp.rdata;
    end
  end

  always_comb begin
    slow_req       = held_req;
    slow_req.valid = slow_valid;
  end

  always_comb begin
    fast_rsp.ready = (state == reply);
    fast_rsp.rdata = (state == reply) ? held_rdata : '0; // Zero between replies.
  end

endmodule

`default_nettype wire

// ==== verilog/slow_fabric.sv ====
`default_nettype none

`include "bus_params.svh"

module slow_fabric (
  input  logic              clock,
  input  logic              reset,
  input  logic              slow_tick,
  input  bus_pkg::mem_req_t slow_req,
  output bus_pkg::mem_rsp_t slow_rsp,
  output bus_pkg::mem_req_t ram_req,
  input  bus_pkg::mem_rsp_t ram_rsp,
  output bus_pkg::mem_req_t timer_req,
  input  bus_pkg::mem_rsp_t timer_rsp
);
  import bus_pkg::*;

  localparam addr_t ram_base    = `BUS_RAM_BASE;
  localparam addr_t ram_bytes   = addr_t'(`BUS_RAM_WORDS * 4);
  localparam addr_t timer_base  = `BUS_TIMER_BASE;
  localparam addr_t timer_bytes = addr_t'(12); // Three words.

  addr_t ram_offset;
  addr_t timer_offset;
  logic  ram_hit;
  logic  timer_hit;
  logic  unmapped_hit;
  logic  unmapped_ready;
  data_t ram_rdata;
  data_t timer_rdata;

  // Offsets wrap below the base, so one compare covers each range.
  assign ram_offset   = slow_req.addr - ram_base;
  assign timer_offset = slow_req.addr - timer_base;

  assign ram_hit      = (ram_offset < ram_bytes);
  assign timer_hit    = (timer_offset < timer_bytes) && !ram_hit;
  assign unmapped_hit = !ram_hit && !timer_hit;

  always_comb begin
    ram_req         = slow_req;
    ram_req.valid   = slow_req.valid && ram_hit;
    timer_req       = slow_req;
    timer_req.valid = slow_req.valid && timer_hit;
  end

  // Unmapped responder, same handshake as a target.
  always_ff @(posedge clock) begin
    if (!reset) begin
      unmapped_ready <= 1'b0;
    end else if (slow_tick) begin
      unmapped_ready <= slow_req.valid && unmapped_hit && !unmapped_ready;
    end
  end

  // Only a ready target contributes data.
  assign ram_rdata   = ram_rsp.ready ? ram_rsp.rdata : '0;
  assign timer_rdata = timer_rsp.ready ? timer_rsp.rdata : '0;

  always_comb begin
    slow_rsp.ready = ram_rsp.ready || timer_rsp.ready || unmapped_ready;
    slow_rsp.rdata = ram_rdata | timer_rdata;
  end

endmodule

`default_nettype wire

// ==== verilog/slow_ram.sv ====
`default_nettype none

`include "bus_params.svh"

module slow_ram (
  input  logic              clock,
  input  logic              reset,
  input  logic              slow_tick,
  input  bus_pkg::mem_req_t req,
  output bus_pkg::mem_rsp_t rsp
);
  import bus_pkg::*;

  localparam int    words       = `BUS_RAM_WORDS;
  localparam int    index_width = $clog2(words);
  localparam addr_t base        = `BUS_RAM_BASE;

  data_t                  mem [words];
  addr_t                  offset;
  logic [index_width-1:0] index;
  logic                   accept;
  logic                   write;
  logic                   ready_q;
  data_t                  rdata_q;

  assign offset = req.addr - base;
  assign index  = offset[index_width+1:2]; // Word index.
  assign accept = slow_tick && req.valid && !ready_q;
  assign write  = |req.wstrb;

  // Ready for one slow period per access.
  always_ff @(posedge clock) begin
    if (!reset) begin
      ready_q <= 1'b0;
    end else if (slow_tick) begin
      ready_q <= accept;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      if (write) begin
        for (int b = 0; b < 4; b++) begin
          if (req.wstrb[b]) begin
            mem[index][8*b +: 8] <= req.wdata[8*b +: 8];
          end
        end
        rdata_q <= '0; // Writes answer with zero.
      end else begin
        rdata_q <= mem[index];
      end
    end
  end

  assign rsp.ready = ready_q;
  assign rsp.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== verilog/slow_timer.sv ====
`default_nettype none

`include "bus_params.svh"

module slow_timer (
  input  logic              clock,
  input  logic              reset,
  input  logic              slow_tick,
  input  bus_pkg::mem_req_t req,
  output bus_pkg::mem_rsp_t rsp
);
  import bus_pkg::*;

  localparam addr_t base = `BUS_TIMER_BASE;

  addr_t      offset;
  logic [1:0] sel;
  logic       accept;
  logic       write;
  logic       count_write;
  logic       compare_write;
  logic       match_clear;
  logic       match_hit;
  data_t      count_q;
  data_t      compare_q;
  logic       match_q;
  logic       ready_q;
  data_t      read_word;
  data_t      rdata_q;

  function automatic data_t merge_bytes(data_t old_word, data_t new_word, strobe_t strobe);
    data_t result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strobe[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  assign offset = req.addr - base;
  assign sel    = offset[3:2];
  assign accept = slow_tick && req.valid && !ready_q;
  assign write  = |req.wstrb;

  assign count_write   = accept && write && (sel == 2'd0);
  assign compare_write = accept && write && (sel == 2'd1);
  assign match_clear   = accept && write && (sel == 2'd2) && req.wstrb[0] && req.wdata[0];
  assign match_hit     = (count_q == compare_q);

  always_ff @(posedge clock) begin
    if (!reset) begin
      count_q   <= '0;
      compare_q <= '1; // Far from count after reset.
      match_q   <= 1'b0;
      ready_q   <= 1'b0;
    end else if (slow_tick) begin
      ready_q <= accept;
      if (count_write) begin
        count_q <= merge_bytes(count_q, req.wdata, req.wstrb);
      end else begin
        count_q <= count_q + 1'b1;
      end
      if (compare_write) begin
        compare_q <= merge_bytes(compare_q, req.wdata, req.wstrb);
      end
      // A new match beats a clear in the same tick.
      match_q <= (match_q && !match_clear) || match_hit;
    end
  end

  always_comb begin
    case (sel)
      2'd0:    read_word = count_q;
      2'd1:    read_word = compare_q;
      2'd2:    read_word = {31'b0, match_q};
      default: read_word = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      rdata_q <= write ? '0 : read_word;
    end
  end

  assign rsp.ready = ready_q;
  assign rsp.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== verilog/mem_subsystem.sv ====
`default_nettype none

module mem_subsystem (
  input  logic              clock,
  input  logic              reset,
  input  bus_pkg::mem_req_t fast_req,
  output bus_pkg::mem_rsp_t fast_rsp
);
  import bus_pkg::*;

  logic     slow_tick;
  mem_req_t slow_req;
  mem_rsp_t slow_rsp;
  mem_req_t ram_req;
  mem_rsp_t ram_rsp;
  mem_req_t timer_req;
  mem_rsp_t timer_rsp;

  rate_bridge rate_bridge_i (
    .clock     (clock),
    .reset     (reset),
    .fast_req  (fast_req),
    .fast_rsp  (fast_rsp),
    .slow_tick (slow_tick),
    .slow_req  (slow_req),
    .slow_rsp  (slow_rsp)
  );

  slow_fabric slow_fabric_i (
    .clock     (clock),
    .reset     (reset),
    .slow_tick (slow_tick),
    .slow_req  (slow_req),
    .slow_rsp  (slow_rsp),
    .ram_req   (ram_req),
    .ram_rsp   (ram_rsp),
    .timer_req (timer_req),
    .timer_rsp (timer_rsp)
  );

  slow_ram slow_ram_i (
    .clock     (clock),
    .reset     (reset),
    .slow_tick (slow_tick),
    .req       (ram_req),
    .rsp       (ram_rsp)
  );

  slow_timer slow_timer_i (
    .clock     (clock),
    .reset     (reset),
    .slow_tick (slow_tick),
    .req       (timer_req),
    .rsp       (timer_rsp)
  );

endmodule

`default_nettype wire

// ==== tb/mem_subsystem_tb.sv ====
`default_nettype none

`include "bus_params.svh"

module mem_subsystem_tb;
  import bus_pkg::*;

  typedef enum logic [1:0] {
    kind_write,
    kind_read,
    kind_poll
  } kind_t;

  typedef struct packed {
    kind_t   kind;
    addr_t   addr;
    data_t   wdata;
    strobe_t wstrb;
    data_t   expected;
  } row_t;

  localparam int reset_cycles = 10;
  localparam int poll_limit   = 64;
  localparam addr_t timer_count   = `BUS_TIMER_BASE;
  localparam addr_t timer_compare = `BUS_TIMER_BASE + 32'h4;
  localparam addr_t timer_flag    = `BUS_TIMER_BASE + 32'h8;
  localparam addr_t ram_last      = `BUS_RAM_BASE + 32'((`BUS_RAM_WORDS - 1) * 4);

  logic     clock;
  logic     reset;
  mem_req_t fast_req;
  mem_rsp_t fast_rsp;

  row_t rows[$];
  logic pending;
  int   cycle_count;
  int   cycle_limit;

  mem_subsystem mem_subsystem_i (
    .clock    (clock),
    .reset    (reset),
    .fast_req (fast_req),
    .fast_rsp (fast_rsp)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] time %0t: %s is %h, expected %h", $time, name, actual, expected);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  // Old bytes kept where the strobe is clear.
  function automatic data_t strobe_merge(data_t old_word, data_t new_word, strobe_t strobe);
    data_t mask;
    mask = {{8{strobe[3]}}, {8{strobe[2]}}, {8{strobe[1]}}, {8{strobe[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  task automatic add_row(input kind_t kind, input addr_t addr, input data_t wdata,
                         input strobe_t wstrb, input data_t expected);
    row_t row;
    row.kind     = kind;
    row.addr     = addr;
    row.wdata    = wdata;
    row.wstrb    = wstrb;
    row.expected = expected;
    rows.push_back(row);
  endtask

  task automatic build_table();
    addr_t ram_addr[5];
    data_t ram_word[5];
    data_t partial[3];
    data_t merged;
    ram_addr[0] = `BUS_RAM_BASE;
    ram_addr[1] = `BUS_RAM_BASE + 32'h4;
    ram_addr[2] = `BUS_RAM_BASE + 32'h44;
    ram_addr[3] = `BUS_RAM_BASE + 32'h200;
    ram_addr[4] = ram_last;
    for (int i = 0; i < 5; i++) begin
      ram_word[i] = $urandom();
    end
    for (int i = 0; i < 3; i++) begin
      partial[i] = $urandom();
    end

    // Full words including the first and last.
    for (int i = 0; i < 5; i++) begin
      add_row(kind_write, ram_addr[i], ram_word[i], 4'hf, 32'h0);
    end
    for (int i = 0; i < 5; i++) begin
      add_row(kind_read, ram_addr[i], 32'h0, 4'h0, ram_word[i]);
    end

    // Partial writes into word 2.
    add_row(kind_write, 32'h8, partial[0], 4'hf, 32'h0);
    merged = strobe_merge(partial[0], partial[1], 4'b0101);
    add_row(kind_write, 32'h8, partial[1], 4'b0101, 32'h0);
    add_row(kind_read, 32'h8, 32'h0, 4'h0, merged);
    merged = strobe_merge(merged, partial[2], 4'b1000);
    add_row(kind_write, 32'h8, partial[2], 4'b1000, 32'h0);
    add_row(kind_read, 32'h8, 32'h0, 4'h0, merged);

    // Timer.
    add_row(kind_write, timer_count, 32'h0, 4'hf, 32'h0);
    add_row(kind_write, timer_compare, 32'd5, 4'hf, 32'h0);
    add_row(kind_poll, timer_flag, 32'h0, 4'h0, 32'h1);
    add_row(kind_write, timer_flag, 32'h1, 4'h1, 32'h0);
    add_row(kind_read, timer_flag, 32'h0, 4'h0, 32'h0);
    add_row(kind_read, timer_compare, 32'h0, 4'h0, 32'd5);

    // Unmapped addresses just past the RAM and past the timer words.
    add_row(kind_write, 32'h2000_0000, 32'hdead_beef, 4'hf, 32'h0);
    add_row(kind_read, 32'h2000_0000, 32'h0, 4'h0, 32'h0);
    add_row(kind_write, 32'h0000_0400, 32'h1234_5678, 4'hf, 32'h0);
    add_row(kind_read, 32'h0000_0400, 32'h0, 4'h0, 32'h0);
    add_row(kind_read, 32'h1000_000c, 32'h0, 4'h0, 32'h0);
    add_row(kind_read, ram_addr[0], 32'h0, 4'h0, ram_word[0]);
    add_row(kind_read, ram_addr[4], 32'h0, 4'h0, ram_word[4]);
  endtask

  // Holds one request until the ready pulse and then idles a cycle.
  task automatic run_access(input addr_t addr, input data_t wdata, input strobe_t wstrb,
                            output data_t rdata);
    @(posedge clock);
    #2;
    fast_req.valid = 1'b1;
    fast_req.addr  = addr;
    fast_req.wdata = wdata;
    fast_req.wstrb = wstrb;
    pending        = 1'b1;
    @(negedge clock);
    while (!fast_rsp.ready) begin
      @(negedge clock);
    end
    rdata = fast_rsp.rdata;
    @(posedge clock);
    #2;
    fast_req = '0;
    pending  = 1'b0;
    @(negedge clock);
    check_value("fast_rsp.ready after pulse", {31'b0, fast_rsp.ready}, 32'h0);
  endtask

  // Catches a ready pulse that comes with no request.
  always @(negedge clock) begin
    if (fast_rsp.ready && !pending) begin
      check_value("fast_rsp.ready while idle", 32'h1, 32'h0);
    end
  end

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit != 0 && cycle_count > cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles.", cycle_limit);
      $display("Test FAILED");
      $fatal(1);
    end
  end

  initial begin
    row_t  row;
    data_t rdata;
    int    tries;
    reset        = 1'b0;
    fast_req     = '0;
    pending      = 1'b0;
    cycle_count  = 0;
    cycle_limit  = 0;
    void'($urandom(89));
    build_table();
    cycle_limit = rows.size() * poll_limit * (3 * `BUS_CLOCK_RATIO + 1) + reset_cycles;

    repeat (reset_cycles) @(posedge clock);
    #2;
    reset = 1'b1;

    for (int i = 0; i < rows.size(); i++) begin
      row = rows[i];
      if (row.kind == kind_poll) begin
        run_access(row.addr, row.wdata, row.wstrb, rdata);
        tries = 1;
        while (rdata != row.expected && tries < poll_limit) begin
          run_access(row.addr, row.wdata, row.wstrb, rdata);
          tries++;
        end
        if (rdata != row.expected) begin
          $display("Poll of address %h did not read %h within %0d reads.",
                   row.addr, row.expected, poll_limit);
          $display("Test FAILED");
          $fatal(1);
        end
      end else begin
        run_access(row.addr, row.wdata, row.wstrb, rdata); // Writes answer with zero.
      end
      check_value($sformatf("fast_rsp.rdata (row %0d)", i), rdata, row.expected);
    end

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+common
common/bus_pkg.sv
bridge/rate_bridge.sv
verilog/slow_fabric.sv
verilog/slow_ram.sv
verilog/slow_timer.sv
verilog/mem_subsystem.sv
tb/mem_subsystem_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module mem_subsystem_tb \
  -f list.f -o mem_subsystem_sim \
  || { echo "Build failed"; exit 1; }

output=$(./obj_dir/mem_subsystem_sim)
echo "$output"

echo "$output" | grep -qx "Test OK" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
